//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = datapath_tb
FILELIST  = compile.f
LOG       = sim.log
FAIL_MSG  = Simulation FAILED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- common/cpu_types_pkg.sv
// shared types for the single-cycle core
// opcode and funct enums cover only the supported subset
// instr_t overlays the R, I and J formats on one 32-bit word
`default_nettype none

package cpu_types_pkg;

  // data path width
  localparam int WORD_W = 32;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [4:0]        regbits_t;

  // supported opcodes only
  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_BEQ   = 6'b000100,
    OP_BNE   = 6'b000101,
    OP_ADDIU = 6'b001001,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_LUI   = 6'b001111,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  // r-type function field
  typedef enum logic [5:0] {
    F_SLL  = 6'b000000,
    F_JR   = 6'b001000,
    F_ADDU = 6'b100001,
    F_SUBU = 6'b100011,
    F_AND  = 6'b100100,
    F_OR   = 6'b100101,
    F_XOR  = 6'b100110,
    F_SLT  = 6'b101010
  } funct_t;

  typedef enum logic [3:0] {
    ALU_SLL = 4'd0,
    ALU_ADD = 4'd1,
    ALU_SUB = 4'd2,
    ALU_AND = 4'd3,
    ALU_OR  = 4'd4,
    ALU_XOR = 4'd5,
    ALU_SLT = 4'd6
  } aluop_t;

  // instruction formats, msb first
  typedef struct packed {
    opcode_t  opcode;
    regbits_t rs;
    regbits_t rt;
    regbits_t rd;
    regbits_t shamt;
    funct_t   funct;
  } r_type_t;

  typedef struct packed {
    opcode_t     opcode;
    regbits_t    rs;
    regbits_t    rt;
    logic [15:0] imm;
  } i_type_t;

  typedef struct packed {
    opcode_t     opcode;
    logic [25:0] addr;
  } j_type_t;

  // one fetched word, three views
  typedef union packed {
    r_type_t r;
    i_type_t i;
    j_type_t j;
  } instr_t;

  // halt is the all-ones word
  localparam word_t HALT_WORD = 32'hffff_ffff;

  // next-pc select, shared by control and pc
  localparam logic [1:0] PC_SEQ    = 2'd0;
  localparam logic [1:0] PC_BRANCH = 2'd1;
  localparam logic [1:0] PC_JUMP   = 2'd2;
  localparam logic [1:0] PC_JREG   = 2'd3;

endpackage

`default_nettype wire

//--- compile.f
common/cpu_types_pkg.sv
design/alu.sv
design/register_file.sv
design/control_unit.sv
design/program_counter.sv
design/request_unit.sv
design/datapath.sv
verification/datapath_tb.sv

//--- design/alu.sv
// combinational alu for the supported subset
// overflow is a flag only, no trap is raised
// sll shifts port_b by shamt, port_a is ignored
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  cpu_types_pkg::aluop_t   alu_op,
  input  cpu_types_pkg::word_t    port_a,
  input  cpu_types_pkg::word_t    port_b,
  input  cpu_types_pkg::regbits_t shamt,
  output cpu_types_pkg::word_t    result,
  output logic                    negative,
  output logic                    overflow,
  output logic                    zero
);
  import cpu_types_pkg::*;

  always_comb begin
    result   = '0;
    overflow = 1'b0;
    case (alu_op)
      ALU_SLL: begin
        // rt shifted, as in the r-type encoding
        result = port_b << shamt;
      end
      ALU_ADD: begin
        result   = port_a + port_b;
        // same-sign operands, result sign flipped
        overflow = (port_a[31] == port_b[31]) && (result[31] != port_a[31]);
      end
      ALU_SUB: begin
        result   = port_a - port_b;
        // opposite-sign operands, sign taken from b
        overflow = (port_a[31] != port_b[31]) && (result[31] != port_a[31]);
      end
      ALU_AND: begin
        result = port_a & port_b;
      end
      ALU_OR: begin
        result = port_a | port_b;
      end
      ALU_XOR: begin
        result = port_a ^ port_b;
      end
      ALU_SLT: begin
        // signed compare
        result = {31'b0, $signed(port_a) < $signed(port_b)};
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // flags from the final result
  assign negative = result[31];
  assign zero     = (result == '0);

endmodule

`default_nettype wire

//--- design/control_unit.sv
// instruction decode for the single-cycle core
// imemload must stay valid while imemaddr is held during a data access
// halt latches on the completing halt word and clears only on reset
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  logic                    CLK,
  input  logic                    rst,
  input  cpu_types_pkg::word_t    instr,
  input  logic                    ihit,
  input  logic                    alu_zero,
  output cpu_types_pkg::regbits_t rs,
  output cpu_types_pkg::regbits_t rt,
  output cpu_types_pkg::regbits_t rd,
  output cpu_types_pkg::regbits_t shamt,
  output cpu_types_pkg::word_t    imm_ext,
  output logic [25:0]             jump_target,
  output cpu_types_pkg::aluop_t   alu_op,
  output logic                    alu_src,
  output logic                    reg_dst,
  output logic                    mem_to_reg,
  output logic                    reg_wen,
  output logic                    mem_ren,
  output logic                    mem_wen,
  output logic [1:0]              pc_src,
  output logic                    halt
);
  import cpu_types_pkg::*;

  instr_t ir;
  logic   is_halt;
  logic   halt_q;

  // one word, three formats
  assign ir = instr_t'(instr);

  // register fields sit at the same place in r and i formats
  assign rs          = ir.r.rs;
  assign rt          = ir.r.rt;
  assign rd          = ir.r.rd;
  assign shamt       = ir.r.shamt;
  assign jump_target = ir.j.addr;

  assign is_halt = (instr == HALT_WORD);

  always_comb begin
    // defaults, a no-op
    alu_op     = ALU_ADD;
    alu_src    = 1'b0;
    reg_dst    = 1'b0;
    mem_to_reg = 1'b0;
    reg_wen    = 1'b0;
    mem_ren    = 1'b0;
    mem_wen    = 1'b0;
    pc_src     = PC_SEQ;
    // sign extension unless the opcode says otherwise
    imm_ext    = {{16{ir.i.imm[15]}}, ir.i.imm};
    case (ir.r.opcode)
      OP_RTYPE: begin
        reg_dst = 1'b1;
        reg_wen = 1'b1;
        case (ir.r.funct)
          F_SLL:  alu_op = ALU_SLL;
          F_ADDU: alu_op = ALU_ADD;
          F_SUBU: alu_op = ALU_SUB;
          F_AND:  alu_op = ALU_AND;
          F_OR:   alu_op = ALU_OR;
          F_XOR:  alu_op = ALU_XOR;
          F_SLT:  alu_op = ALU_SLT;
          F_JR: begin
            reg_wen = 1'b0;
            pc_src  = PC_JREG;
          end
          default: reg_wen = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        alu_src = 1'b1;
        reg_wen = 1'b1;
      end
      OP_ANDI: begin
        alu_op  = ALU_AND;
        alu_src = 1'b1;
        reg_wen = 1'b1;
        imm_ext = {16'b0, ir.i.imm};
      end
      OP_ORI: begin
        alu_op  = ALU_OR;
        alu_src = 1'b1;
        reg_wen = 1'b1;
        imm_ext = {16'b0, ir.i.imm};
      end
      OP_LUI: begin
        // rs is zero in the encoding, so the add passes the constant
        alu_src = 1'b1;
        reg_wen = 1'b1;
        imm_ext = {ir.i.imm, 16'b0};
      end
      OP_LW: begin
        alu_src    = 1'b1;
        reg_wen    = 1'b1;
        mem_to_reg = 1'b1;
        mem_ren    = 1'b1;
      end
      OP_SW: begin
        alu_src = 1'b1;
        mem_wen = 1'b1;
      end
      OP_BEQ: begin
        // rs - rt, taken on zero
        alu_op = ALU_SUB;
        if (alu_zero) pc_src = PC_BRANCH;
      end
      OP_BNE: begin
        alu_op = ALU_SUB;
        if (!alu_zero) pc_src = PC_BRANCH;
      end
      OP_J: begin
        pc_src = PC_JUMP;
      end
      default: begin
        // halt and unsupported words do nothing
        pc_src = PC_SEQ;
      end
    endcase
  end

  // sticky halt flag
  always_ff @(posedge CLK) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else if (ihit && is_halt) begin
      halt_q <= 1'b1;
    end
  end

  // high already in the completing cycle so the pc stays on the halt word
  assign halt = halt_q | (ihit & is_halt);

endmodule

`default_nettype wire

//--- design/datapath.sv
// single-cycle mips subset core, top level
// memories are external; each enable is held until its hit
// imemload must stay valid while imemaddr is stable
`timescale 1ns/10ps
`default_nettype none

module datapath #(
  parameter logic [31:0] PC_INIT = 32'h0
) (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 ihit,
  input  cpu_types_pkg::word_t imemload,
  input  logic                 dhit,
  input  cpu_types_pkg::word_t dmemload,
  output logic                 imemREN,
  output cpu_types_pkg::word_t imemaddr,
  output logic                 dmemREN,
  output logic                 dmemWEN,
  output cpu_types_pkg::word_t dmemaddr,
  output cpu_types_pkg::word_t dmemstore,
  output logic                 halt
);
  import cpu_types_pkg::*;

  // decode outputs
  regbits_t    rs;
  regbits_t    rt;
  regbits_t    rd;
  regbits_t    shamt;
  word_t       imm_ext;
  logic [25:0] jump_target;
  aluop_t      alu_op;
  logic        alu_src;
  logic        reg_dst;
  logic        mem_to_reg;
  logic        reg_wen;
  logic        mem_ren;
  logic        mem_wen;
  logic [1:0]  pc_src;

  // register file and alu
  regbits_t wsel;
  word_t    wdat;
  word_t    rdat1;
  word_t    rdat2;
  word_t    alu_b;
  word_t    alu_result;
  logic     alu_zero;

  // completion
  logic mem_req;
  logic mem_pending;
  logic pc_en;

  control_unit control_unit_i (
    .CLK(CLK), .rst(rst), .instr(imemload), .ihit(ihit), .alu_zero(alu_zero),
    .rs(rs), .rt(rt), .rd(rd), .shamt(shamt), .imm_ext(imm_ext),
    .jump_target(jump_target), .alu_op(alu_op), .alu_src(alu_src),
    .reg_dst(reg_dst), .mem_to_reg(mem_to_reg), .reg_wen(reg_wen),
    .mem_ren(mem_ren), .mem_wen(mem_wen), .pc_src(pc_src), .halt(halt)
  );

  // writes land on the completing edge only
  register_file register_file_i (
    .CLK(CLK), .rst(rst), .wen(reg_wen & pc_en), .wsel(wsel), .wdat(wdat),
    .rsel1(rs), .rsel2(rt), .rdat1(rdat1), .rdat2(rdat2)
  );

  program_counter #(.PC_INIT(PC_INIT)) program_counter_i (
    .CLK(CLK), .rst(rst), .pc_en(pc_en), .pc_src(pc_src), .imm_ext(imm_ext),
    .jump_target(jump_target), .rdat1(rdat1), .imemaddr(imemaddr)
  );

  // negative and overflow not needed, no traps in this core
  alu alu_i (
    .alu_op(alu_op), .port_a(rdat1), .port_b(alu_b), .shamt(shamt),
    .result(alu_result), .negative(), .overflow(), .zero(alu_zero)
  );

  request_unit request_unit_i (
    .CLK(CLK), .rst(rst), .ihit(ihit), .dhit(dhit), .mem_ren(mem_ren),
    .mem_wen(mem_wen), .dmemREN(dmemREN), .dmemWEN(dmemWEN)
  );

  // operand b: register or immediate
  assign alu_b = alu_src ? imm_ext : rdat2;

  // rd for r-type, rt otherwise
  assign wsel = reg_dst ? rd : rt;

  // load data or alu result
  assign wdat = mem_to_reg ? dmemload : alu_result;

  // data port follows the decode of the held instruction
  assign dmemaddr  = alu_result;
  assign dmemstore = rdat2;

  assign mem_req     = mem_ren | mem_wen;
  assign mem_pending = dmemREN | dmemWEN;

  // done on ihit, or on dhit once the data access is out
  assign pc_en = !halt && (mem_req ? (mem_pending && dhit) : ihit);

  // fetch stops once halted
  assign imemREN = !halt;

endmodule

`default_nettype wire

//--- design/program_counter.sv
// program counter with next-pc select
// branch offset is the extended immediate shifted left by two
// jump keeps the upper four bits of pc + 4
`timescale 1ns/10ps
`default_nettype none

module program_counter #(
  parameter logic [31:0] PC_INIT = 32'h0
) (
  input  logic                 CLK,
  input  logic                 rst,
  input  logic                 pc_en,
  input  logic [1:0]           pc_src,
  input  cpu_types_pkg::word_t imm_ext,
  input  logic [25:0]          jump_target,
  input  cpu_types_pkg::word_t rdat1,
  output cpu_types_pkg::word_t imemaddr
);
  import cpu_types_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    case (pc_src)
      PC_BRANCH: pc_next = pc_plus4 + {imm_ext[29:0], 2'b00};
      PC_JUMP:   pc_next = {pc_plus4[31:28], jump_target, 2'b00};
      PC_JREG:   pc_next = rdat1;
      default:   pc_next = pc_plus4;
    endcase
  end

  // advance only when the instruction completes
  always_ff @(posedge CLK) begin
    if (rst) begin
      pc <= PC_INIT;
    end else if (pc_en) begin
      pc <= pc_next;
    end
  end

  assign imemaddr = pc;

  // jr takes a register value, so alignment is not guaranteed by decode
  a_pc_aligned : assert property (@(posedge CLK) disable iff (rst) imemaddr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- design/register_file.sv
// 32 x 32 register file, two async reads, one sync write
// register zero is cleared by reset and never written, so it reads as zero
`timescale 1ns/10ps
`default_nettype none

module register_file (
  input  logic                    CLK,
  input  logic                    rst,
  input  logic                    wen,
  input  cpu_types_pkg::regbits_t wsel,
  input  cpu_types_pkg::word_t    wdat,
  input  cpu_types_pkg::regbits_t rsel1,
  input  cpu_types_pkg::regbits_t rsel2,
  output cpu_types_pkg::word_t    rdat1,
  output cpu_types_pkg::word_t    rdat2
);
  import cpu_types_pkg::*;

  // r0 kept in storage, held at zero
  word_t regs [0:31];

  always_ff @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (wsel != '0)) begin
      // writes to r0 dropped here
      regs[wsel] <= wdat;
    end
  end

  // combinational reads, r0 included
  assign rdat1 = regs[rsel1];
  assign rdat2 = regs[rsel2];

  // r0 reads zero on either port
  a_r0_zero : assert property (@(posedge CLK) disable iff (rst)
    (rsel1 != '0 || rdat1 == '0) && (rsel2 != '0 || rdat2 == '0));

endmodule

`default_nettype wire

//--- design/request_unit.sv
// data memory request unit
// enables are issued once per instruction after ihit and held until dhit
`timescale 1ns/10ps
`default_nettype none

module request_unit (
  input  logic CLK,
  input  logic rst,
  input  logic ihit,
  input  logic dhit,
  input  logic mem_ren,
  input  logic mem_wen,
  output logic dmemREN,
  output logic dmemWEN
);

  logic pending;

  assign pending = dmemREN | dmemWEN;

  always_ff @(posedge CLK) begin
    if (rst) begin
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (pending && dhit) begin
      // access done, drop both
      dmemREN <= 1'b0;
      dmemWEN <= 1'b0;
    end else if (!pending && ihit) begin
      // fetch done, issue what the decode asks for
      dmemREN <= mem_ren;
      dmemWEN <= mem_wen;
    end
  end

  // read and write never requested together
  a_one_enable : assert property (@(posedge CLK) disable iff (rst) !(dmemREN && dmemWEN));
  // a data hit only answers an outstanding request
  a_hit_pending : assert property (@(posedge CLK) disable iff (rst) dhit |-> pending);

endmodule

`default_nettype wire

//--- verification/datapath_tb.sv
// testbench for the single-cycle core, harvard memories modelled here
// program, initial data and expected stores come from program_stim.txt
// hits are one-cycle pulses after a random 0..3 cycle latency
`timescale 1ns/10ps
`default_nettype none

module datapath_tb;

  localparam int STIM_WORDS   = 128;
  localparam int DATA_BASE    = 64;
  localparam int STORE_COUNT  = 80;
  localparam int STORE_BASE   = 81;
  localparam int GROUP_BASE   = 124;
  localparam int HALT_IDX     = 127;
  localparam int DMEM_WORDS   = 32;
  localparam int RESET_CYCLES = 8;
  localparam int POST_HALT    = 10;
  // every skipped slot stores to this address
  localparam logic [31:0] MARKER_ADDR = 32'h0000_007c;

  logic        CLK;
  logic        rst;
  logic        ihit;
  logic        dhit;
  logic [31:0] imemload;
  logic [31:0] dmemload;
  logic        imemREN;
  logic        dmemREN;
  logic        dmemWEN;
  logic        halt;
  logic [31:0] imemaddr;
  logic [31:0] dmemaddr;
  logic [31:0] dmemstore;

  logic [31:0] stim [0:STIM_WORDS-1];
  logic [31:0] dmem [0:DMEM_WORDS-1];
  integer      seed;
  int          cycles;
  int          cycle_limit;
  int          store_idx;
  int          ilat;
  int          dlat;
  int          halt_cycles;
  int          test_err [1:6];
  logic        reported [1:6];
  logic        d_busy;
  logic        halt_seen;
  // snapshot from the previous falling edge
  logic        dhold;
  logic        ihold;
  logic        prev_ren;
  logic        prev_wen;
  logic [31:0] prev_daddr;
  logic [31:0] prev_dstore;
  logic [31:0] prev_iaddr;

  datapath #(.PC_INIT(32'h0)) datapath_i (
    .CLK(CLK), .rst(rst), .ihit(ihit), .imemload(imemload), .dhit(dhit),
    .dmemload(dmemload), .imemREN(imemREN), .imemaddr(imemaddr), .dmemREN(dmemREN),
    .dmemWEN(dmemWEN), .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt)
  );

  always #50 CLK = ~CLK;

  task automatic check_word(input int t, input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR %s: expected %h, got %h", name, exp, got);
      test_err[t]++;
    end
  endtask

  task automatic check_bit(input int t, input string name, input logic got, input logic exp);
    assert (got === exp) else begin
      $display("ERROR %s: expected %h, got %h", name, exp, got);
      test_err[t]++;
    end
  endtask

  task automatic report_test(input int t, input string name);
    reported[t] = 1'b1;
    $display("test %0d %s: %s", t, name, (test_err[t] == 0) ? "ok" : "errors");
  endtask

  task automatic release_reset();
    check_word(1, "imemaddr", imemaddr, 32'h0);
    check_bit(1, "dmemREN", dmemREN, 1'b0);
    check_bit(1, "dmemWEN", dmemWEN, 1'b0);
    check_bit(1, "halt", halt, 1'b0);
    check_bit(1, "imemREN", imemREN, 1'b1);
    rst = 1'b0;
    report_test(1, "reset state");
  endtask

  // compare one completed store with the next expected entry
  task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
    int t;
    t = (store_idx <= int'(stim[GROUP_BASE])) ? 2 :
        (store_idx <= int'(stim[GROUP_BASE+1])) ? 3 : 4;
    assert (addr != MARKER_ADDR) else begin
      $display("store from a skipped path reached memory at %h", addr);
      test_err[4]++;
    end
    assert (store_idx < int'(stim[STORE_COUNT])) else begin
      $display("store beyond the expected list at %h", addr);
      test_err[6]++;
    end
    if (store_idx < int'(stim[STORE_COUNT])) begin
      check_word(t, "dmemaddr", addr, stim[STORE_BASE+2*store_idx]);
      check_word(t, "dmemstore", data, stim[STORE_BASE+2*store_idx+1]);
      if (store_idx == int'(stim[GROUP_BASE])) report_test(2, "alu and immediate results");
      if (store_idx == int'(stim[GROUP_BASE+1])) report_test(3, "loads");
      if (store_idx == int'(stim[GROUP_BASE+2])) report_test(4, "control flow");
      store_idx++;
    end
    dmem[addr[6:2]] = data;
  endtask

  task automatic step_memories();
    // hold checks against the last falling edge
    if (dhold) begin
      check_bit(5, "dmemREN", dmemREN, prev_ren);
      check_bit(5, "dmemWEN", dmemWEN, prev_wen);
      check_word(5, "dmemaddr", dmemaddr, prev_daddr);
      check_word(5, "dmemstore", dmemstore, prev_dstore);
    end
    if (ihold) check_word(5, "imemaddr", imemaddr, prev_iaddr);
    if (halt && !halt_seen) begin
      halt_seen = 1'b1;
      check_word(6, "imemaddr", imemaddr, stim[HALT_IDX]);
    end
    if (halt_seen) begin
      halt_cycles++;
      check_bit(6, "dmemWEN", dmemWEN, 1'b0);
      // fetch stays off once halted
      check_bit(6, "imemREN", imemREN, 1'b0);
    end
    prev_ren    = dmemREN;
    prev_wen    = dmemWEN;
    prev_daddr  = dmemaddr;
    prev_dstore = dmemstore;
    prev_iaddr  = imemaddr;
    // data side, dhit lasts one cycle
    if (dhit) begin
      dhit = 1'b0;
    end else if (dmemREN || dmemWEN) begin
      if (!d_busy) begin
        d_busy = 1'b1;
        dlat   = $unsigned($random(seed)) % 4;
      end
      if (dlat == 0) begin
        dhit   = 1'b1;
        d_busy = 1'b0;
        if (dmemWEN) record_store(dmemaddr, dmemstore);
        else dmemload = dmem[dmemaddr[6:2]];
      end else begin
        dlat--;
      end
    end
    // fetch side, imemload always follows the pc
    if (imemREN) begin
      if (ilat == 0) begin
        ihit = 1'b1;
        ilat = $unsigned($random(seed)) % 4;
      end else begin
        ihit = 1'b0;
        ilat--;
      end
    end else begin
      ihit = 1'b0;
    end
    imemload = (imemaddr < 32'h100) ? stim[imemaddr[7:2]] : 32'hffff_ffff;
    dhold = (prev_ren || prev_wen) && !dhit;
    ihold = prev_ren | prev_wen | imemREN ? (!ihit && !dhit) : 1'b0;
  endtask

  task automatic finish_run();
    int total;
    int failed;
    assert (store_idx == int'(stim[STORE_COUNT])) else begin
      $display("only %0d of %0d expected stores were seen", store_idx, stim[STORE_COUNT]);
      test_err[6]++;
    end
    if (!reported[2]) report_test(2, "alu and immediate results");
    if (!reported[3]) report_test(3, "loads");
    if (!reported[4]) report_test(4, "control flow");
    report_test(5, "back-pressure");
    report_test(6, "halt");
    total  = 0;
    failed = 0;
    for (int t = 1; t <= 6; t++) begin
      total += test_err[t];
      if (test_err[t] != 0) failed++;
    end
    $display("tests 6, failed %0d, errors %0d", failed, total);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout();
    $display("timeout: halt plus %0d cycles not reached within %0d cycles",
             POST_HALT, cycle_limit);
    $display("Simulation FAILED");
    $finish;
  endtask

  initial begin
    CLK      = 1'b0;
    rst      = 1'b1;
    ihit     = 1'b0;
    dhit     = 1'b0;
    imemload = '0;
    dmemload = '0;
    seed     = 32'h1d23_502a;
    for (int i = 0; i < STIM_WORDS; i++) stim[i] = {16'hdead, i[15:0]};
    $readmemh("verification/program_stim.txt", stim);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = (i < 16) ? stim[DATA_BASE+i] : {16'hda7a, i[15:0]};
    end
    // program length from the halt word position
    cycle_limit = (int'(stim[HALT_IDX] >> 2) + 1) * 5 + 100;
    cycles      = 0;
    store_idx   = 0;
    halt_cycles = 0;
    halt_seen   = 1'b0;
    d_busy      = 1'b0;
    dhold       = 1'b0;
    ihold       = 1'b0;
    dlat        = 0;
    ilat        = $unsigned($random(seed)) % 4;
    for (int t = 1; t <= 6; t++) begin
      test_err[t] = 0;
      reported[t] = 1'b0;
    end
  end

  always @(negedge CLK) begin
    cycles++;
    if (cycles > cycle_limit) begin
      report_timeout();
    end else if (cycles == RESET_CYCLES) begin
      release_reset();
    end else if (halt_cycles >= POST_HALT) begin
      finish_run();
    end else if (cycles > RESET_CYCLES) begin
      step_memories();
    end
  end

endmodule

`default_nettype wire

//--- verification/program_stim.txt
// @00 program words, @40 initial data words, @50 store count,
// @51 expected (dmemaddr, dmemstore) pairs, @7c last store of each group, @7f halt pc
@00
24010005 2402fffd 00221821 ac030040
00222023 ac040044 0041282a ac050048
3c06abcd 34c61234 ac06004c 30c7ff00
00c74026 ac080050 00014900 01215025
ac0a0054 8c0b0000 8c0c0004 016c6821
ac0d0058 016d7024 ac0e005c 10220002
14210002 10210001 ac02007c 14220001
ac02007c ac010060 08000021 ac02007c
ac02007c 24100094 02000008 ac02007c
ac02007c ac100064 ffffffff
@40
00001234 00000042
@50
0000000a
00000040 00000002
00000044 00000008
00000048 00000001
0000004c abcd1234
00000050 abcd0034
00000054 00000055
00000058 00001276
0000005c 00001234
00000060 00000005
00000064 00000094
@7c
00000005 00000007 00000009
@7f
00000098
